//--- logic/axi_pkg.sv
`include "dc_params.svh"

package axi_pkg;

    typedef logic [7:0] len_t;
    typedef logic [2:0] size_t;
    typedef logic [1:0] burst_t;
    typedef logic [1:0] resp_t;

    typedef logic [`AXI_ID_WIDTH-1:0] id_t;
    typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`AXI_DATA_WIDTH-1:0] data_t;
    typedef logic [`AXI_DATA_WIDTH/8-1:0] strb_t;

    // Write address request
    typedef struct packed {
        addr_t      addr;
        id_t        id;
        len_t       len;
        size_t      size;
        burst_t     burst;
        logic       lock;
        logic [3:0] cache;
        logic [2:0] prot;
    } aw_chan_t;

    // One write data beat
    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } w_chan_t;

    // Write response
    typedef struct packed {
        id_t   id;
        resp_t resp;
    } b_chan_t;

endpackage

//--- logic/dc_fifo_din.sv
`timescale 1ns/100ps

`include "dc_params.svh"

module dc_fifo_din #(
    parameter type chan_t = logic
) (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           valid_i,
    output logic           ready_o,
    input  chan_t          data_i,
    output dc_pkg::token_t write_token_o,
    input  dc_pkg::token_t read_pointer_i,
    output chan_t          data_async_o
);

    chan_t          buffer_q [`DC_BUFFER_WIDTH];
    dc_pkg::token_t write_token_q;
    dc_pkg::token_t write_token_next;
    dc_pkg::token_t rp_meta_q;
    dc_pkg::token_t rp_sync_q;
    dc_pkg::slot_t  wr_slot;
    dc_pkg::slot_t  rd_slot;
    logic           full;
    logic           push;

    function automatic dc_pkg::slot_t to_slot(input dc_pkg::token_t t);
        dc_pkg::slot_t s;
        s = '0;
        for (int i = 0; i < `DC_BUFFER_WIDTH; i++) begin
            if (t[i]) begin
                s = dc_pkg::slot_t'(i);
            end
        end
        return s;
    endfunction

    assign write_token_next = {write_token_q[`DC_BUFFER_WIDTH-2:0],
                               write_token_q[`DC_BUFFER_WIDTH-1]};

    // One slot always stays empty so full and empty differ
    assign full    = (write_token_next == rp_sync_q);
    assign ready_o = ~full;
    assign push    = valid_i & ~full;

    assign wr_slot = to_slot(write_token_q);
    assign rd_slot = to_slot(read_pointer_i);

    // Remote side reads the slot under its own pointer
    assign data_async_o  = buffer_q[rd_slot];
    assign write_token_o = write_token_q;

    always_ff @(posedge clk_i) begin
        if (push) begin
            buffer_q[wr_slot] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            write_token_q <= dc_pkg::token_t'(1);
            rp_meta_q     <= dc_pkg::token_t'(1);
            rp_sync_q     <= dc_pkg::token_t'(1);
        end else begin
            rp_meta_q <= read_pointer_i;
            rp_sync_q <= rp_meta_q;
            if (push) begin
                write_token_q <= write_token_next;
            end
        end
    end

endmodule

//--- logic/dc_fifo_dout.sv
`timescale 1ns/100ps

module dc_fifo_dout (
    input  logic             clk_i,
    input  logic             rst_i,
    input  axi_pkg::b_chan_t data_async_i,
    input  dc_pkg::token_t   write_token_i,
    output dc_pkg::token_t   read_pointer_o,
    output logic             valid_o,
    input  logic             ready_i,
    output axi_pkg::b_chan_t data_o
);

    dc_pkg::token_t wt_meta_q;
    dc_pkg::token_t wt_sync_q;
    dc_pkg::token_t read_pointer_q;
    dc_pkg::token_t read_pointer_next;
    logic           pop;

    assign read_pointer_next = {read_pointer_q[$bits(dc_pkg::token_t)-2:0],
                                read_pointer_q[$bits(dc_pkg::token_t)-1]};

    // Entry pending while our pointer trails the synchronized token
    assign valid_o = (read_pointer_q != wt_sync_q);
    assign pop     = valid_o & ready_i;

    // Remote slot is selected by read_pointer_o and settled before its token moved
    assign data_o         = data_async_i;
    assign read_pointer_o = read_pointer_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wt_meta_q <= dc_pkg::token_t'(1);
            wt_sync_q <= dc_pkg::token_t'(1);
        end else begin
            wt_meta_q <= write_token_i;
            wt_sync_q <= wt_meta_q;
        end
    end

    // Moving the pointer hands the slot back to the remote writer
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            read_pointer_q <= dc_pkg::token_t'(1);
        end else if (pop) begin
            read_pointer_q <= read_pointer_next;
        end
    end

endmodule

//--- logic/dc_params.svh
`ifndef DC_PARAMS_SVH
`define DC_PARAMS_SVH

// AXI field widths
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 64
`define AXI_ID_WIDTH 6

// Slots in each token ring
`define DC_BUFFER_WIDTH 8

// Entries ahead of the B outputs
`define RESP_BUFFER_DEPTH 2

`endif

//--- logic/dc_pkg.sv
`include "dc_params.svh"

package dc_pkg;

    // One-hot over the ring slots, used for write tokens and read pointers
    typedef logic [`DC_BUFFER_WIDTH-1:0] token_t;

    // Binary index of a ring slot
    typedef logic [$clog2(`DC_BUFFER_WIDTH)-1:0] slot_t;

endpackage

//--- logic/dc_slice_slave.sv
`timescale 1ns/100ps

module dc_slice_slave (
    input  logic              clk_i,
    input  logic              rst_i,

    // Write address from the local master
    input  logic              aw_valid_i,
    output logic              aw_ready_o,
    input  axi_pkg::addr_t    aw_addr_i,
    input  axi_pkg::id_t      aw_id_i,
    input  axi_pkg::len_t     aw_len_i,
    input  axi_pkg::size_t    aw_size_i,
    input  axi_pkg::burst_t   aw_burst_i,
    input  logic              aw_lock_i,
    input  logic [3:0]        aw_cache_i,
    input  logic [2:0]        aw_prot_i,

    // Write data from the local master
    input  logic              w_valid_i,
    output logic              w_ready_o,
    input  axi_pkg::data_t    w_data_i,
    input  axi_pkg::strb_t    w_strb_i,
    input  logic              w_last_i,

    // Write response to the local master
    output logic              b_valid_o,
    input  logic              b_ready_i,
    output axi_pkg::id_t      b_id_o,
    output axi_pkg::resp_t    b_resp_o,

    // Remote domain side
    output axi_pkg::aw_chan_t m_aw_data_o,
    output dc_pkg::token_t    m_aw_writetoken_o,
    input  dc_pkg::token_t    m_aw_readpointer_i,
    output axi_pkg::w_chan_t  m_w_data_o,
    output dc_pkg::token_t    m_w_writetoken_o,
    input  dc_pkg::token_t    m_w_readpointer_i,
    input  axi_pkg::b_chan_t  m_b_data_i,
    input  dc_pkg::token_t    m_b_writetoken_i,
    output dc_pkg::token_t    m_b_readpointer_o
);

    axi_pkg::aw_chan_t aw_data;
    axi_pkg::w_chan_t  w_data;
    axi_pkg::b_chan_t  b_dc_data;
    axi_pkg::b_chan_t  b_data;
    logic              b_dc_valid;
    logic              b_dc_ready;

    assign aw_data.addr  = aw_addr_i;
    assign aw_data.id    = aw_id_i;
    assign aw_data.len   = aw_len_i;
    assign aw_data.size  = aw_size_i;
    assign aw_data.burst = aw_burst_i;
    assign aw_data.lock  = aw_lock_i;
    assign aw_data.cache = aw_cache_i;
    assign aw_data.prot  = aw_prot_i;

    assign w_data.data = w_data_i;
    assign w_data.strb = w_strb_i;
    assign w_data.last = w_last_i;

    assign b_id_o   = b_data.id;
    assign b_resp_o = b_data.resp;

    dc_fifo_din #(
        .chan_t ( axi_pkg::aw_chan_t )
    ) u_aw_fifo (
        .clk_i          ( clk_i              ),
        .rst_i          ( rst_i              ),
        .valid_i        ( aw_valid_i         ),
        .ready_o        ( aw_ready_o         ),
        .data_i         ( aw_data            ),
        .write_token_o  ( m_aw_writetoken_o  ),
        .read_pointer_i ( m_aw_readpointer_i ),
        .data_async_o   ( m_aw_data_o        )
    );

    dc_fifo_din #(
        .chan_t ( axi_pkg::w_chan_t )
    ) u_w_fifo (
        .clk_i          ( clk_i             ),
        .rst_i          ( rst_i             ),
        .valid_i        ( w_valid_i         ),
        .ready_o        ( w_ready_o         ),
        .data_i         ( w_data            ),
        .write_token_o  ( m_w_writetoken_o  ),
        .read_pointer_i ( m_w_readpointer_i ),
        .data_async_o   ( m_w_data_o        )
    );

    // Responses cross inward, then wait in a small buffer for b_ready_i
    dc_fifo_dout u_b_fifo (
        .clk_i          ( clk_i             ),
        .rst_i          ( rst_i             ),
        .data_async_i   ( m_b_data_i        ),
        .write_token_i  ( m_b_writetoken_i  ),
        .read_pointer_o ( m_b_readpointer_o ),
        .valid_o        ( b_dc_valid        ),
        .ready_i        ( b_dc_ready        ),
        .data_o         ( b_dc_data         )
    );

    resp_buffer u_b_buffer (
        .clk_i   ( clk_i      ),
        .rst_i   ( rst_i      ),
        .valid_i ( b_dc_valid ),
        .ready_o ( b_dc_ready ),
        .data_i  ( b_dc_data  ),
        .valid_o ( b_valid_o  ),
        .ready_i ( b_ready_i  ),
        .data_o  ( b_data     )
    );

endmodule

//--- logic/resp_buffer.sv
`timescale 1ns/100ps

`include "dc_params.svh"

module resp_buffer (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             valid_i,
    output logic             ready_o,
    input  axi_pkg::b_chan_t data_i,
    output logic             valid_o,
    input  logic             ready_i,
    output axi_pkg::b_chan_t data_o
);

    localparam int DEPTH   = `RESP_BUFFER_DEPTH;
    localparam int IDX_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(DEPTH + 1);

    axi_pkg::b_chan_t   mem_q [DEPTH];
    logic [IDX_W-1:0]   wr_idx_q;
    logic [IDX_W-1:0]   rd_idx_q;
    logic [COUNT_W-1:0] count_q;
    logic               push;
    logic               pop;

    assign ready_o = (count_q != COUNT_W'(DEPTH));
    assign valid_o = (count_q != '0);
    assign push    = valid_i & ready_o;
    assign pop     = valid_o & ready_i;

    // Head entry stays put until the local master takes it
    assign data_o = mem_q[rd_idx_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_idx_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_idx_q <= '0;
            rd_idx_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_idx_q <= (wr_idx_q == IDX_W'(DEPTH - 1)) ? '0 : wr_idx_q + 1'b1;
            end
            if (pop) begin
                rd_idx_q <= (rd_idx_q == IDX_W'(DEPTH - 1)) ? '0 : rd_idx_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_dc_slice_slave -f verilog.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "ALL CHECKS PASSED" sim.log && exit 0 || exit 1

//--- sim/dc_slice_slave_chk.sv
`timescale 1ns/100ps

module dc_slice_slave_chk (
    input logic           clk_i,
    input logic           rst_i,
    input logic           aw_valid_i,
    input logic           aw_ready_o,
    input logic           w_valid_i,
    input logic           w_ready_o,
    input logic           b_valid_o,
    input logic           b_ready_i,
    input axi_pkg::id_t   b_id_o,
    input axi_pkg::resp_t b_resp_o,
    input dc_pkg::token_t m_aw_writetoken_o,
    input dc_pkg::token_t m_w_writetoken_o,
    input dc_pkg::token_t m_b_readpointer_o
);

    assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot(m_aw_writetoken_o) && $onehot(m_w_writetoken_o) && $onehot(m_b_readpointer_o))
        else $error("token or pointer is not one-hot");

    assert property (@(posedge clk_i) disable iff (rst_i)
        !$stable(m_aw_writetoken_o) |-> $past(aw_valid_i && aw_ready_o))
        else $error("AW write token moved without a handshake");

    assert property (@(posedge clk_i) disable iff (rst_i)
        !$stable(m_w_writetoken_o) |-> $past(w_valid_i && w_ready_o))
        else $error("W write token moved without a handshake");

    // Response must hold until the master takes it
    assert property (@(posedge clk_i) disable iff (rst_i)
        b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_id_o) && $stable(b_resp_o))
        else $error("B response changed while stalled");

    assert property (@(posedge clk_i)
        $fell(rst_i) |-> aw_ready_o && w_ready_o && !b_valid_o)
        else $error("ready or valid wrong right after reset");

endmodule

bind dc_slice_slave dc_slice_slave_chk u_chk (
    .clk_i             ( clk_i             ),
    .rst_i             ( rst_i             ),
    .aw_valid_i        ( aw_valid_i        ),
    .aw_ready_o        ( aw_ready_o        ),
    .w_valid_i         ( w_valid_i         ),
    .w_ready_o         ( w_ready_o         ),
    .b_valid_o         ( b_valid_o         ),
    .b_ready_i         ( b_ready_i         ),
    .b_id_o            ( b_id_o            ),
    .b_resp_o          ( b_resp_o          ),
    .m_aw_writetoken_o ( m_aw_writetoken_o ),
    .m_w_writetoken_o  ( m_w_writetoken_o  ),
    .m_b_readpointer_o ( m_b_readpointer_o )
);

//--- sim/tb_dc_slice_slave.sv
`timescale 1ns/100ps

`include "dc_params.svh"

module tb_dc_slice_slave;

    localparam int NUM = 10;

    logic              clk_i;
    logic              rst_i;
    logic              aw_valid_i;
    logic              aw_ready_o;
    axi_pkg::aw_chan_t aw_drive;
    logic              w_valid_i;
    logic              w_ready_o;
    axi_pkg::w_chan_t  w_drive;
    logic              b_valid_o;
    logic              b_ready_i;
    axi_pkg::id_t      b_id_o;
    axi_pkg::resp_t    b_resp_o;
    axi_pkg::aw_chan_t m_aw_data_o;
    dc_pkg::token_t    m_aw_writetoken_o;
    dc_pkg::token_t    m_aw_readpointer_i;
    axi_pkg::w_chan_t  m_w_data_o;
    dc_pkg::token_t    m_w_writetoken_o;
    dc_pkg::token_t    m_w_readpointer_i;
    axi_pkg::b_chan_t  m_b_data_i;
    dc_pkg::token_t    m_b_writetoken_i;
    dc_pkg::token_t    m_b_readpointer_o;

    // Stimulus table and expected order at the far side
    axi_pkg::aw_chan_t aw_tab [NUM];
    axi_pkg::w_chan_t  w_tab [NUM];
    axi_pkg::b_chan_t  b_tab [NUM];

    // Remote domain model
    axi_pkg::b_chan_t  b_mem [`DC_BUFFER_WIDTH];
    dc_pkg::token_t    aw_wt_meta;
    dc_pkg::token_t    aw_wt_sync;
    dc_pkg::token_t    w_wt_meta;
    dc_pkg::token_t    w_wt_sync;
    dc_pkg::token_t    b_rp_meta;
    dc_pkg::token_t    b_rp_sync;
    int                b_freed;

    int                aw_idx;
    int                w_idx;
    int                b_idx;
    int                aw_rd_idx;
    int                w_rd_idx;
    int                b_wr_idx;
    logic              aw_acc;
    logic              w_acc;
    logic              b_staged;
    logic              aw_hold;
    logic              b_stall;
    logic [31:0]       rng;
    int                errors;
    int                cycles;

    dc_slice_slave dut_i (
        .clk_i              ( clk_i              ),
        .rst_i              ( rst_i              ),
        .aw_valid_i         ( aw_valid_i         ),
        .aw_ready_o         ( aw_ready_o         ),
        .aw_addr_i          ( aw_drive.addr      ),
        .aw_id_i            ( aw_drive.id        ),
        .aw_len_i           ( aw_drive.len       ),
        .aw_size_i          ( aw_drive.size      ),
        .aw_burst_i         ( aw_drive.burst     ),
        .aw_lock_i          ( aw_drive.lock      ),
        .aw_cache_i         ( aw_drive.cache     ),
        .aw_prot_i          ( aw_drive.prot      ),
        .w_valid_i          ( w_valid_i          ),
        .w_ready_o          ( w_ready_o          ),
        .w_data_i           ( w_drive.data       ),
        .w_strb_i           ( w_drive.strb       ),
        .w_last_i           ( w_drive.last       ),
        .b_valid_o          ( b_valid_o          ),
        .b_ready_i          ( b_ready_i          ),
        .b_id_o             ( b_id_o             ),
        .b_resp_o           ( b_resp_o           ),
        .m_aw_data_o        ( m_aw_data_o        ),
        .m_aw_writetoken_o  ( m_aw_writetoken_o  ),
        .m_aw_readpointer_i ( m_aw_readpointer_i ),
        .m_w_data_o         ( m_w_data_o         ),
        .m_w_writetoken_o   ( m_w_writetoken_o   ),
        .m_w_readpointer_i  ( m_w_readpointer_i  ),
        .m_b_data_i         ( m_b_data_i         ),
        .m_b_writetoken_i   ( m_b_writetoken_i   ),
        .m_b_readpointer_o  ( m_b_readpointer_o  )
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic dc_pkg::token_t rotl(input dc_pkg::token_t t);
        return {t[`DC_BUFFER_WIDTH-2:0], t[`DC_BUFFER_WIDTH-1]};
    endfunction

    function automatic dc_pkg::slot_t onehot_index(input dc_pkg::token_t t);
        dc_pkg::slot_t idx;
        idx = '0;
        for (int i = 0; i < `DC_BUFFER_WIDTH; i++) begin
            if (t[i]) begin
                idx = dc_pkg::slot_t'(i);
            end
        end
        return idx;
    endfunction

    // The DUT reads the remote B slot under its own read pointer
    assign m_b_data_i = b_mem[onehot_index(m_b_readpointer_o)];

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        if (rst_i) begin
            aw_wt_meta <= dc_pkg::token_t'(1);
            aw_wt_sync <= dc_pkg::token_t'(1);
            w_wt_meta  <= dc_pkg::token_t'(1);
            w_wt_sync  <= dc_pkg::token_t'(1);
            b_rp_meta  <= dc_pkg::token_t'(1);
            b_rp_sync  <= dc_pkg::token_t'(1);
            b_freed    <= 0;
        end else begin
            aw_wt_meta <= m_aw_writetoken_o;
            aw_wt_sync <= aw_wt_meta;
            w_wt_meta  <= m_w_writetoken_o;
            w_wt_sync  <= w_wt_meta;
            b_rp_meta  <= m_b_readpointer_o;
            b_rp_sync  <= b_rp_meta;
            // Each pointer step seen by the remote writer frees one slot
            if (b_rp_meta != b_rp_sync) begin
                b_freed <= b_freed + 1;
            end
        end
    end

    task automatic fail_now(input string what);
        errors++;
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_aw(input string name, input axi_pkg::aw_chan_t got,
                            input axi_pkg::aw_chan_t exp);
        if (got !== exp) begin
            fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_w(input string name, input axi_pkg::w_chan_t got,
                           input axi_pkg::w_chan_t exp);
        if (got !== exp) begin
            fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_b(input string name, input axi_pkg::b_chan_t got,
                           input axi_pkg::b_chan_t exp);
        if (got !== exp) begin
            fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_token(input string name, input dc_pkg::token_t got,
                               input dc_pkg::token_t exp);
        if (got !== exp) begin
            fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic fill_tables();
        aw_tab[0] = '{32'h0000_1000, 6'h01, 8'h00, 3'h3, 2'h1, 1'b0, 4'h0, 3'h0};
        aw_tab[1] = '{32'h0000_2040, 6'h02, 8'h03, 3'h3, 2'h1, 1'b0, 4'h3, 3'h1};
        aw_tab[2] = '{32'hdead_beef, 6'h3f, 8'hff, 3'h0, 2'h0, 1'b1, 4'hf, 3'h7};
        aw_tab[3] = '{32'h8000_0000, 6'h10, 8'h01, 3'h2, 2'h2, 1'b0, 4'h2, 3'h2};
        aw_tab[4] = '{32'h1234_5678, 6'h2a, 8'h07, 3'h3, 2'h1, 1'b1, 4'ha, 3'h5};
        aw_tab[5] = '{32'hffff_fff8, 6'h00, 8'h0f, 3'h1, 2'h0, 1'b0, 4'h1, 3'h3};
        aw_tab[6] = '{32'h0a0a_0a00, 6'h15, 8'h80, 3'h3, 2'h2, 1'b1, 4'h5, 3'h4};
        aw_tab[7] = '{32'h5555_aaa0, 6'h2b, 8'h02, 3'h2, 2'h1, 1'b0, 4'hc, 3'h6};
        aw_tab[8] = '{32'h0000_0008, 6'h07, 8'h00, 3'h3, 2'h1, 1'b0, 4'h7, 3'h0};
        aw_tab[9] = '{32'hc0de_f000, 6'h31, 8'h40, 3'h0, 2'h3, 1'b1, 4'h9, 3'h1};
        w_tab[0] = '{64'h0123_4567_89ab_cdef, 8'hff, 1'b1};
        w_tab[1] = '{64'hfedc_ba98_7654_3210, 8'h0f, 1'b0};
        w_tab[2] = '{64'h0000_0000_0000_0000, 8'h00, 1'b0};
        w_tab[3] = '{64'hffff_ffff_ffff_ffff, 8'hf0, 1'b1};
        w_tab[4] = '{64'hdead_beef_cafe_f00d, 8'h81, 1'b0};
        w_tab[5] = '{64'h1111_2222_3333_4444, 8'h3c, 1'b1};
        w_tab[6] = '{64'ha5a5_5a5a_a5a5_5a5a, 8'haa, 1'b0};
        w_tab[7] = '{64'h8000_0000_0000_0001, 8'h55, 1'b0};
        w_tab[8] = '{64'h0f0f_0f0f_f0f0_f0f0, 8'h01, 1'b1};
        w_tab[9] = '{64'h7777_8888_9999_aaaa, 8'h80, 1'b1};
        b_tab[0] = '{6'h01, 2'b00};
        b_tab[1] = '{6'h02, 2'b01};
        b_tab[2] = '{6'h3f, 2'b10};
        b_tab[3] = '{6'h10, 2'b11};
        b_tab[4] = '{6'h2a, 2'b00};
        b_tab[5] = '{6'h00, 2'b10};
        b_tab[6] = '{6'h15, 2'b01};
        b_tab[7] = '{6'h2b, 2'b00};
        b_tab[8] = '{6'h07, 2'b11};
        b_tab[9] = '{6'h31, 2'b00};
    endtask

    // One clock of local master, remote domain and local B consumer
    task automatic run_cycle();
        axi_pkg::b_chan_t b_got;
        @(negedge clk_i);
        rng = xorshift(rng);

        // A word that was not taken stays on the bus
        if (!(aw_valid_i && !aw_acc)) begin
            aw_valid_i = (aw_idx < NUM) && rng[0];
        end
        if (aw_idx < NUM) begin
            aw_drive = aw_tab[aw_idx];
        end
        aw_acc = aw_valid_i && aw_ready_o;
        if (aw_acc) begin
            aw_idx++;
        end

        if (!(w_valid_i && !w_acc)) begin
            w_valid_i = (w_idx < NUM) && rng[1];
        end
        if (w_idx < NUM) begin
            w_drive = w_tab[w_idx];
        end
        w_acc = w_valid_i && w_ready_o;
        if (w_acc) begin
            w_idx++;
        end

        if (!aw_hold && m_aw_readpointer_i != aw_wt_sync && rng[2]) begin
            if (aw_rd_idx >= NUM) begin
                fail_now("the remote AW side saw a request that was never sent");
            end
            check_aw("m_aw_data_o", m_aw_data_o, aw_tab[aw_rd_idx]);
            aw_rd_idx++;
            m_aw_readpointer_i = rotl(m_aw_readpointer_i);
        end

        if (m_w_readpointer_i != w_wt_sync && rng[5]) begin
            if (w_rd_idx >= NUM) begin
                fail_now("the remote W side saw a beat that was never sent");
            end
            check_w("m_w_data_o", m_w_data_o, w_tab[w_rd_idx]);
            w_rd_idx++;
            m_w_readpointer_i = rotl(m_w_readpointer_i);
        end

        // Slot data goes in one cycle before the token moves
        if (b_staged) begin
            m_b_writetoken_i = rotl(m_b_writetoken_i);
            b_staged = 1'b0;
            b_wr_idx++;
            if (b_wr_idx - b_freed > 7) begin
                fail_now("the remote B writer found more than seven responses outstanding");
            end
        end else if (b_wr_idx < NUM && rotl(m_b_writetoken_i) != b_rp_sync && rng[3]) begin
            b_mem[onehot_index(m_b_writetoken_i)] = b_tab[b_wr_idx];
            b_staged = 1'b1;
        end

        b_ready_i = !b_stall && rng[4];
        if (b_ready_i && b_valid_o) begin
            if (b_idx >= NUM) begin
                fail_now("b_valid_o was high with no response left to deliver");
            end
            b_got.id   = b_id_o;
            b_got.resp = b_resp_o;
            check_b("b_id_o/b_resp_o", b_got, b_tab[b_idx]);
            b_idx++;
        end
    endtask

    initial begin
        rng    = 32'd86000;
        errors = 0;
        fill_tables();
        rst_i              = 1'b1;
        aw_valid_i         = 1'b0;
        aw_drive           = '0;
        w_valid_i          = 1'b0;
        w_drive            = '0;
        b_ready_i          = 1'b0;
        m_aw_readpointer_i = dc_pkg::token_t'(1);
        m_w_readpointer_i  = dc_pkg::token_t'(1);
        m_b_writetoken_i   = dc_pkg::token_t'(1);
        for (int i = 0; i < `DC_BUFFER_WIDTH; i++) begin
            b_mem[i] = '0;
        end
        aw_idx    = 0;
        w_idx     = 0;
        b_idx     = 0;
        aw_rd_idx = 0;
        w_rd_idx  = 0;
        b_wr_idx  = 0;
        aw_acc    = 1'b0;
        w_acc     = 1'b0;
        b_staged  = 1'b0;
        aw_hold   = 1'b1;
        b_stall   = 1'b1;

        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        @(negedge clk_i);
        check_bit("aw_ready_o", aw_ready_o, 1'b1);
        check_bit("w_ready_o", w_ready_o, 1'b1);
        check_bit("b_valid_o", b_valid_o, 1'b0);
        check_token("m_aw_writetoken_o", m_aw_writetoken_o, 8'h01);
        check_token("m_w_writetoken_o", m_w_writetoken_o, 8'h01);
        check_token("m_b_readpointer_o", m_b_readpointer_o, 8'h01);

        // AW pointer held and B stalled so seven requests fit and B holds 2 plus 7
        cycles = 0;
        while (!(aw_idx >= 7 && b_wr_idx >= 9)) begin
            if (cycles == 400) begin
                fail_now("timeout while filling the AW ring and the B path under stall");
            end
            run_cycle();
            cycles++;
        end
        for (int i = 0; i < 20; i++) begin
            run_cycle();
            check_bit("aw_ready_o", aw_ready_o, 1'b0);
        end
        check_count("aw accepted", aw_idx, 7);
        check_count("b written", b_wr_idx, 9);
        check_bit("b_valid_o", b_valid_o, 1'b1);

        aw_hold = 1'b0;
        b_stall = 1'b0;
        cycles  = 0;
        while (!(aw_rd_idx == NUM && w_rd_idx == NUM && b_idx == NUM)) begin
            if (cycles == 3000) begin
                fail_now("timeout before all AW, W and B traffic had drained");
            end
            run_cycle();
            cycles++;
        end
        @(negedge clk_i);
        check_bit("b_valid_o", b_valid_o, 1'b0);
        check_token("m_aw_writetoken_o", m_aw_writetoken_o, 8'h04);
        check_token("m_w_writetoken_o", m_w_writetoken_o, 8'h04);
        check_token("m_b_readpointer_o", m_b_readpointer_o, 8'h04);

        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+logic
logic/axi_pkg.sv
logic/dc_pkg.sv
logic/dc_fifo_din.sv
logic/dc_fifo_dout.sv
logic/resp_buffer.sv
logic/dc_slice_slave.sv
sim/dc_slice_slave_chk.sv
sim/tb_dc_slice_slave.sv
